/* list.f */
+incdir+hdl
hdl/afe_pkg.sv
hdl/adc_frontend.sv
hdl/output_limit.sv
hdl/afe_regs.sv
hdl/analog_top.sv
test/tb_analog_top.sv

/* run.sh */
#!/bin/sh
# build and run the analog data path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f list.f --top-module tb_analog_top --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi
exit 0

/* test/tb_analog_top.sv */
// analog data path testbench
`timescale 1ns/1ns
`include "afe_params.svh"

module tb_analog_top;

  import afe_pkg::*;

  localparam int SMP_MAX     = 2**(`AFE_SMP_W-1) - 1;
  localparam int SMP_MIN     = -(2**(`AFE_SMP_W-1));
  localparam int ACK_TIMEOUT = 16;   // cycles

  typedef logic [`AFE_SMP_W-1:0] code_t;

  typedef struct packed {
    sample_t lim;
    logic    low;
    logic    high;
  } lim_res_t;

  // what the DUT saw at one rising edge
  typedef struct packed {
    raw_pair_t    raw;
    sample_pair_t gen;
    sample_pair_t ctl;
    limit_cfg_t   la;
    limit_cfg_t   lb;
    logic         loop;
  } hist_t;

  logic         adc_clk;
  logic         rst_n_i;
  raw_pair_t    adc_raw_i;
  sample_pair_t gen_i;
  sample_pair_t ctl_i;
  sample_pair_t adc_smp_o;
  dac_pair_t    dac_dat_o;
  railed_t      railed_a_o;
  railed_t      railed_b_o;
  sample_t      center_a_o;
  sample_t      center_b_o;
  sys_req_t     sys_req_i;
  sys_rsp_t     sys_rsp_o;

  limit_cfg_t   mdl_lim_a;        // expected register contents
  limit_cfg_t   mdl_lim_b;
  logic         mdl_loop;
  logic [31:0]  lcg_state;
  hist_t        hist [2];         // [0] last edge, [1] the one before
  int           hist_cnt  = 0;
  int           low_hits  = 0;
  int           high_hits = 0;

  analog_top analog_top_i (
    .adc_clk    (adc_clk   ),
    .rst_n_i    (rst_n_i   ),
    .adc_raw_i  (adc_raw_i ),
    .adc_smp_o  (adc_smp_o ),
    .gen_i      (gen_i     ),
    .ctl_i      (ctl_i     ),
    .dac_dat_o  (dac_dat_o ),
    .railed_a_o (railed_a_o),
    .railed_b_o (railed_b_o),
    .center_a_o (center_a_o),
    .center_b_o (center_b_o),
    .sys_req_i  (sys_req_i ),
    .sys_rsp_o  (sys_rsp_o )
  );

  always #2 adc_clk = ~adc_clk;   // 4 ns period

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // mostly random, now and then a rail to force overflow
  function automatic sample_t pick_sample(input logic [31:0] r);
    case (r[17:15])
      3'd0:    return sample_t'(SMP_MAX);
      3'd1:    return sample_t'(SMP_MIN);
      default: return sample_t'(r[31:18]);
    endcase
  endfunction

  // negative slope: full scale code reads as the most negative value
  function automatic sample_t conv_ref(input logic [`AFE_RAW_W-1:0] raw);
    return sample_t'(SMP_MAX - int'(raw[`AFE_RAW_W-1:`AFE_RAW_W-`AFE_SMP_W]));
  endfunction

  function automatic code_t code_ref(input sample_t s);
    return code_t'(SMP_MAX - int'(s));   // offset binary, inverted slope
  endfunction

  function automatic lim_res_t limit_ref(input sample_t g, input sample_t c,
                                         input limit_cfg_t cfg);
    lim_res_t r;
    sample_t  mn;
    sample_t  mx;
    int       s;
    mn     = cfg.min;
    mx     = cfg.max;
    s      = int'(g) + int'(c);
    r.low  = 1'b0;
    r.high = 1'b0;
    if (s > SMP_MAX)
      s = SMP_MAX;                        // saturate first
    else if (s < SMP_MIN)
      s = SMP_MIN;
    if (s < int'(mn))
    begin
      s     = int'(mn);
      r.low = 1'b1;
    end
    else if (s > int'(mx))
    begin
      s      = int'(mx);
      r.high = 1'b1;
    end
    r.lim = sample_t'(s);
    return r;
  endfunction

  // floor of the midpoint, division truncates toward zero
  function automatic sample_t center_ref(input limit_cfg_t cfg);
    sample_t mn;
    sample_t mx;
    int      m;
    mn = cfg.min;
    mx = cfg.max;
    m  = int'(mn) + int'(mx);
    return sample_t'((m >= 0) ? m / 2 : (m - 1) / 2);
  endfunction

  function automatic logic [31:0] word_of(input sample_t v);
    return 32'(int'(v));   // sign extended
  endfunction

  ////////////////////
  // checks
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // capture at the rising edge, compare at the falling one
  always
  begin : compare_proc
    lim_res_t ra0;
    lim_res_t rb0;
    lim_res_t ra1;
    lim_res_t rb1;
    @(posedge adc_clk);
    if (!rst_n_i)
      hist_cnt = 0;
    else
    begin
      hist[1]      = hist[0];
      hist[0].raw  = adc_raw_i;
      hist[0].gen  = gen_i;
      hist[0].ctl  = ctl_i;
      hist[0].la   = mdl_lim_a;
      hist[0].lb   = mdl_lim_b;
      hist[0].loop = mdl_loop;
      if (hist_cnt < 2)
        hist_cnt++;
    end
    @(negedge adc_clk);
    if (hist_cnt >= 2)
    begin
      ra0 = limit_ref(hist[0].gen.ch_a, hist[0].ctl.ch_a, hist[0].la);  // flags, 1 cycle
      rb0 = limit_ref(hist[0].gen.ch_b, hist[0].ctl.ch_b, hist[0].lb);
      ra1 = limit_ref(hist[1].gen.ch_a, hist[1].ctl.ch_a, hist[1].la);  // codes, 2 cycles
      rb1 = limit_ref(hist[1].gen.ch_b, hist[1].ctl.ch_b, hist[1].lb);
      check_val("adc_smp_o.ch_a", word_of(adc_smp_o.ch_a),
                word_of(hist[0].loop ? ra1.lim : conv_ref(hist[1].raw.adc_a)));
      check_val("adc_smp_o.ch_b", word_of(adc_smp_o.ch_b),
                word_of(hist[0].loop ? rb1.lim : conv_ref(hist[1].raw.adc_b)));
      check_val("dac_dat_o.ch_a", 32'(dac_dat_o.ch_a), 32'(code_ref(ra1.lim)));
      check_val("dac_dat_o.ch_b", 32'(dac_dat_o.ch_b), 32'(code_ref(rb1.lim)));
      check_val("railed_a_o", {30'b0, railed_a_o.low, railed_a_o.high},
                {30'b0, ra0.low, ra0.high});
      check_val("railed_b_o", {30'b0, railed_b_o.low, railed_b_o.high},
                {30'b0, rb0.low, rb0.high});
      low_hits  = low_hits + int'(ra0.low) + int'(rb0.low);
      high_hits = high_hits + int'(ra0.high) + int'(rb0.high);
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic drive_cycles(input int n);
    repeat (n)
    begin
      @(negedge adc_clk);
      lcg_state  = lcg_next(lcg_state);
      adc_raw_i  = lcg_state;
      lcg_state  = lcg_next(lcg_state);
      gen_i.ch_a = pick_sample(lcg_state);
      lcg_state  = lcg_next(lcg_state);
      gen_i.ch_b = pick_sample(lcg_state);
      lcg_state  = lcg_next(lcg_state);
      ctl_i.ch_a = pick_sample(lcg_state);
      lcg_state  = lcg_next(lcg_state);
      ctl_i.ch_b = pick_sample(lcg_state);
    end
  endtask

  // one strobe, then wait for the ack pulse
  task automatic bus_access(input logic [7:0] addr, input logic [31:0] wdata,
                            input logic wr, output sys_rsp_t r);
    int n;
    @(negedge adc_clk);
    sys_req_i.addr  = addr;
    sys_req_i.wdata = wdata;
    sys_req_i.wen   = wr;
    sys_req_i.ren   = !wr;
    @(negedge adc_clk);
    sys_req_i.wen = 1'b0;
    sys_req_i.ren = 1'b0;
    n = 0;
    while (!sys_rsp_o.ack && n < ACK_TIMEOUT)
    begin
      @(negedge adc_clk);
      n++;
    end
    if (!sys_rsp_o.ack)
      abort_run($sformatf("register slave never acknowledged access to 0x%h", addr));
    else
      r = sys_rsp_o;
  endtask

  // mapped writes come back without err
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata);
    sys_rsp_t r;
    bus_access(addr, wdata, 1'b1, r);
    check_val("sys_rsp_o.err", {31'b0, r.err}, 32'h0);
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp,
                            input logic exp_err);
    sys_rsp_t r;
    bus_access(addr, 32'h0, 1'b0, r);
    check_val("sys_rsp_o.rdata", r.rdata, exp);
    check_val("sys_rsp_o.err", {31'b0, r.err}, {31'b0, exp_err});
  endtask

  initial
  begin
    adc_clk   = 1'b0;
    rst_n_i   = 1'b0;
    adc_raw_i = '0;
    gen_i     = '0;
    ctl_i     = '0;
    sys_req_i = '0;
    lcg_state = 32'hbd452d62;
    mdl_loop  = 1'b0;
    mdl_lim_a = {sample_t'(`AFE_LIM_MIN_RST), sample_t'(`AFE_LIM_MAX_RST)};
    mdl_lim_b = mdl_lim_a;
    repeat (3) @(negedge adc_clk);
    rst_n_i = 1'b1;

    // conversion and saturation at full range
    drive_cycles(300);
    check_val("center_a_o", word_of(center_a_o), word_of(center_ref(mdl_lim_a)));

    // narrow ranges, model follows each ack
    write_reg(`AFE_REG_MIN_A, word_of(sample_t'(-1000)));
    mdl_lim_a.min = sample_t'(-1000);
    write_reg(`AFE_REG_MAX_A, word_of(sample_t'(1500)));
    mdl_lim_a.max = sample_t'(1500);
    write_reg(`AFE_REG_MIN_B, word_of(sample_t'(-4000)));
    mdl_lim_b.min = sample_t'(-4000);
    write_reg(`AFE_REG_MAX_B, word_of(sample_t'(301)));
    mdl_lim_b.max = sample_t'(301);
    check_val("center_a_o", word_of(center_a_o), word_of(center_ref(mdl_lim_a)));
    check_val("center_b_o", word_of(center_b_o), word_of(center_ref(mdl_lim_b)));
    drive_cycles(300);
    @(posedge adc_clk);
    if (low_hits == 0 || high_hits == 0)
      abort_run("limiter never reached both rails with the narrow ranges");

    // readback, unmapped address flags err
    read_check(`AFE_REG_MIN_A, word_of(mdl_lim_a.min), 1'b0);
    read_check(`AFE_REG_MAX_A, word_of(mdl_lim_a.max), 1'b0);
    read_check(`AFE_REG_MIN_B, word_of(mdl_lim_b.min), 1'b0);
    read_check(`AFE_REG_MAX_B, word_of(mdl_lim_b.max), 1'b0);
    read_check(`AFE_REG_CTRL, 32'h0, 1'b0);
    read_check(8'h40, 32'h0, 1'b1);

    // digital loopback on, then back off
    write_reg(`AFE_REG_CTRL, 32'h1);
    mdl_loop = 1'b1;
    read_check(`AFE_REG_CTRL, 32'h1, 1'b0);
    drive_cycles(200);
    write_reg(`AFE_REG_CTRL, 32'h0);
    mdl_loop = 1'b0;
    drive_cycles(50);

    @(negedge adc_clk);
    $display("Test passed");
    $finish;
  end

endmodule

/* hdl/analog_top.sv */
// analog data path top level
`timescale 1ns/1ns
`include "afe_params.svh"

module analog_top (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // ADC
  input  afe_pkg::raw_pair_t    adc_raw_i,    // raw pin words
  output afe_pkg::sample_pair_t adc_smp_o,    // converted samples
  // DAC sources
  input  afe_pkg::sample_pair_t gen_i,        // generator
  input  afe_pkg::sample_pair_t ctl_i,        // controller
  // DAC
  output afe_pkg::dac_pair_t    dac_dat_o,    // both codes each cycle
  output afe_pkg::railed_t      railed_a_o,
  output afe_pkg::railed_t      railed_b_o,
  output afe_pkg::sample_t      center_a_o,
  output afe_pkg::sample_t      center_b_o,
  // system bus
  input  afe_pkg::sys_req_t     sys_req_i,
  output afe_pkg::sys_rsp_t     sys_rsp_o
);

  import afe_pkg::*;

  logic                  digital_loop;
  limit_cfg_t            lim_a;        // range ch a
  limit_cfg_t            lim_b;        // range ch b
  sample_t               dac_a;        // limited samples
  sample_t               dac_b;
  logic [`AFE_SMP_W-1:0] code_a;       // encoded for DAC
  logic [`AFE_SMP_W-1:0] code_b;

  ////////////////////
  // ADC IO
  ////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .adc_raw_i      (adc_raw_i   ),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dac_a       ),  // loopback source
    .loop_b_i       (dac_b       ),
    .adc_smp_o      (adc_smp_o   )
  );

  ////////////////////
  // DAC IO
  ////////////////////

  output_limit i_limit_a (
    .adc_clk  (adc_clk   ),
    .rst_n_i  (rst_n_i   ),
    .gen_i    (gen_i.ch_a),
    .ctl_i    (ctl_i.ch_a),
    .lim_i    (lim_a     ),
    .lim_o    (dac_a     ),
    .code_o   (code_a    ),
    .railed_o (railed_a_o),
    .center_o (center_a_o)
  );

  output_limit i_limit_b (
    .adc_clk  (adc_clk   ),
    .rst_n_i  (rst_n_i   ),
    .gen_i    (gen_i.ch_b),
    .ctl_i    (ctl_i.ch_b),
    .lim_i    (lim_b     ),
    .lim_o    (dac_b     ),
    .code_o   (code_b    ),
    .railed_o (railed_b_o),
    .center_o (center_b_o)
  );

  assign dac_dat_o.ch_a = code_a;
  assign dac_dat_o.ch_b = code_b;

  ////////////////////
  // configuration
  ////////////////////

  afe_regs i_regs (
    .adc_clk        (adc_clk     ),
    .rst_n_i        (rst_n_i     ),
    .sys_req_i      (sys_req_i   ),
    .sys_rsp_o      (sys_rsp_o   ),
    .digital_loop_o (digital_loop),
    .lim_a_o        (lim_a       ),
    .lim_b_o        (lim_b       )
  );

endmodule

/* hdl/afe_regs.sv */
// analog configuration registers
`timescale 1ns/1ns
`include "afe_params.svh"

module afe_regs (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  afe_pkg::sys_req_t   sys_req_i,
  output afe_pkg::sys_rsp_t   sys_rsp_o,
  output logic                digital_loop_o,  // ADC <- DAC loopback
  output afe_pkg::limit_cfg_t lim_a_o,
  output afe_pkg::limit_cfg_t lim_b_o
);

  import afe_pkg::*;

  reg_sel_e  sel;        // decoded address
  bus_data_t rdata_d;
  logic      access;     // any strobe this cycle

  // limit value -> bus word, sign extended
  function automatic bus_data_t sext(input sample_t v);
    return {{(`AFE_BUS_DW-`AFE_SMP_W){v[`AFE_SMP_W-1]}}, v};
  endfunction

  ////////////////////
  // address decode
  ////////////////////

  always_comb
  begin
    case (sys_req_i.addr)
      `AFE_REG_CTRL:  sel = sel_ctrl;
      `AFE_REG_MIN_A: sel = sel_min_a;
      `AFE_REG_MAX_A: sel = sel_max_a;
      `AFE_REG_MIN_B: sel = sel_min_b;
      `AFE_REG_MAX_B: sel = sel_max_b;
      default:        sel = sel_none;
    endcase
  end

  assign access = sys_req_i.wen | sys_req_i.ren;

  // read mux, unmapped reads as zero
  always_comb
  begin
    case (sel)
      sel_ctrl:  rdata_d = {{(`AFE_BUS_DW-1){1'b0}}, digital_loop_o};
      sel_min_a: rdata_d = sext(lim_a_o.min);
      sel_max_a: rdata_d = sext(lim_a_o.max);
      sel_min_b: rdata_d = sext(lim_b_o.min);
      sel_max_b: rdata_d = sext(lim_b_o.max);
      default:   rdata_d = '0;
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      digital_loop_o <= 1'b0;
      lim_a_o.min    <= sample_t'(`AFE_LIM_MIN_RST);
      lim_a_o.max    <= sample_t'(`AFE_LIM_MAX_RST);
      lim_b_o.min    <= sample_t'(`AFE_LIM_MIN_RST);
      lim_b_o.max    <= sample_t'(`AFE_LIM_MAX_RST);
    end
    else if (sys_req_i.wen)
    begin
      case (sel)
        sel_ctrl:  digital_loop_o <= sys_req_i.wdata[0];
        sel_min_a: lim_a_o.min    <= sys_req_i.wdata[`AFE_SMP_W-1:0];
        sel_max_a: lim_a_o.max    <= sys_req_i.wdata[`AFE_SMP_W-1:0];
        sel_min_b: lim_b_o.min    <= sys_req_i.wdata[`AFE_SMP_W-1:0];
        sel_max_b: lim_b_o.max    <= sys_req_i.wdata[`AFE_SMP_W-1:0];
        default:   ;              // unmapped, flagged by err
      endcase
    end
  end

  // response, always one cycle after the strobe
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      sys_rsp_o.ack <= 1'b0;
      sys_rsp_o.err <= 1'b0;
    end
    else
    begin
      sys_rsp_o.ack <= access;
      sys_rsp_o.err <= access && (sel == sel_none);
    end
  end

  always_ff @(posedge adc_clk)
  begin
    sys_rsp_o.rdata <= sys_req_i.ren ? rdata_d : '0;
  end

  ////////////////////
  // bus protocol
  ////////////////////

  // control write lands together with its ack
  a_write_acked: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (sys_req_i.wen && (sel == sel_ctrl)) |=>
      sys_rsp_o.ack && (digital_loop_o == $past(sys_req_i.wdata[0]))
  );

  a_no_rw: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !(sys_req_i.wen && sys_req_i.ren)
  );

endmodule

/* hdl/output_limit.sv */
// DAC channel sum, limiter and encoder
`timescale 1ns/1ns
`include "afe_params.svh"

module output_limit (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  afe_pkg::sample_t      gen_i,     // generator sample
  input  afe_pkg::sample_t      ctl_i,     // controller sample
  input  afe_pkg::limit_cfg_t   lim_i,     // programmable range
  output afe_pkg::sample_t      lim_o,     // limited sample, also for loopback
  output logic [`AFE_SMP_W-1:0] code_o,    // offset binary to DAC
  output afe_pkg::railed_t      railed_o,
  output afe_pkg::sample_t      center_o   // middle of the range
);

  import afe_pkg::*;

  // DAC code of a zero sample
  localparam logic [`AFE_SMP_W-1:0] CODE_ZERO = {1'b0, {(`AFE_SMP_W-1){1'b1}}};

  logic signed [`AFE_SUM_W-1:0] sum;       // full precision sum
  sample_t                      sat;       // after saturation
  sample_t                      lim_d;
  railed_t                      railed_d;
  logic signed [`AFE_SUM_W-1:0] mid_sum;   // min + max

  ////////////////////
  // sum and saturate
  ////////////////////

  assign sum = gen_i + ctl_i;

  // top two bits differ -> overflow, go to the rail of the sign
  assign sat = (^sum[`AFE_SUM_W-1:`AFE_SUM_W-2]) ?
               {sum[`AFE_SUM_W-1], {(`AFE_SMP_W-1){~sum[`AFE_SUM_W-1]}}} :
               sum[`AFE_SMP_W-1:0];

  ////////////////////
  // clamp to min/max
  ////////////////////

  always_comb
  begin
    lim_d    = sat;
    railed_d = '0;
    if (sat < lim_i.min)
    begin
      lim_d         = lim_i.min;
      railed_d.low  = 1'b1;
    end
    else if (sat > lim_i.max)
    begin
      lim_d         = lim_i.max;
      railed_d.high = 1'b1;
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      lim_o    <= '0;
      railed_o <= '0;
      code_o   <= CODE_ZERO;
    end
    else
    begin
      lim_o    <= lim_d;
      railed_o <= railed_d;
      // signed -> offset binary, negative slope
      code_o   <= {lim_o[`AFE_SMP_W-1], ~lim_o[`AFE_SMP_W-2:0]};
    end
  end

  ////////////////////
  // range centre
  ////////////////////

  // 15 bit sum, arithmetic halving gives the floor
  assign mid_sum  = lim_i.min + lim_i.max;
  assign center_o = mid_sum[`AFE_SUM_W-1:1];

  // a sane range keeps the output inside it, one rail at most
  a_range_held: assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    (lim_i.min <= lim_i.max) |=>
      !(railed_o.low && railed_o.high) &&
      (lim_o >= $past(lim_i.min)) && (lim_o <= $past(lim_i.max))
  );

endmodule

/* hdl/adc_frontend.sv */
// ADC input stage with loopback
`timescale 1ns/1ns
`include "afe_params.svh"

module adc_frontend (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  input  afe_pkg::raw_pair_t    adc_raw_i,       // raw pin words
  input  logic                  digital_loop_i,  // take DAC side values
  input  afe_pkg::sample_t      loop_a_i,        // limited sample ch a
  input  afe_pkg::sample_t      loop_b_i,        // limited sample ch b
  output afe_pkg::sample_pair_t adc_smp_o
);

  import afe_pkg::*;

  logic [`AFE_SMP_W-1:0] raw_a_q;   // reserved lsbs dropped
  logic [`AFE_SMP_W-1:0] raw_b_q;
  sample_t               conv_a;
  sample_t               conv_b;

  // negative slope unsigned -> two's complement
  function automatic sample_t to_twos(input logic [`AFE_SMP_W-1:0] raw);
    return {raw[`AFE_SMP_W-1], ~raw[`AFE_SMP_W-2:0]};
  endfunction

  ////////////////////
  // input registers
  ////////////////////

  // meant to land in the IO block flops
  always_ff @(posedge adc_clk)
  begin
    raw_a_q <= adc_raw_i.adc_a[`AFE_RAW_W-1:`AFE_RAW_W-`AFE_SMP_W];
    raw_b_q <= adc_raw_i.adc_b[`AFE_RAW_W-1:`AFE_RAW_W-`AFE_SMP_W];
  end

  assign conv_a = to_twos(raw_a_q);
  assign conv_b = to_twos(raw_b_q);

  ////////////////////
  // loopback mux
  ////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_smp_o <= '0;
    end
    else if (digital_loop_i)
    begin
      adc_smp_o.ch_a <= loop_a_i;  // DAC path replaces ADC
      adc_smp_o.ch_b <= loop_b_i;
    end
    else
    begin
      adc_smp_o.ch_a <= conv_a;
      adc_smp_o.ch_b <= conv_b;
    end
  end

endmodule

/* hdl/afe_pkg.sv */
// analog front end types
`include "afe_params.svh"

package afe_pkg;

  ////////////////////
  // sample types
  ////////////////////

  typedef logic signed [`AFE_SMP_W-1:0] sample_t;   // two's complement sample

  // raw words straight from the ADC pins
  typedef struct packed {
    logic [`AFE_RAW_W-1:0] adc_a;
    logic [`AFE_RAW_W-1:0] adc_b;
  } raw_pair_t;

  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } sample_pair_t;

  // offset binary, negative slope, as the DAC wants it
  typedef struct packed {
    logic [`AFE_SMP_W-1:0] ch_a;
    logic [`AFE_SMP_W-1:0] ch_b;
  } dac_pair_t;

  typedef struct packed {
    logic low;    // clamped at min
    logic high;   // clamped at max
  } railed_t;

  typedef struct packed {
    sample_t min;
    sample_t max;
  } limit_cfg_t;

  ////////////////////
  // system bus
  ////////////////////

  typedef logic [`AFE_BUS_AW-1:0] bus_addr_t;
  typedef logic [`AFE_BUS_DW-1:0] bus_data_t;

  typedef struct packed {
    bus_addr_t addr;
    bus_data_t wdata;
    logic      wen;     // one cycle write strobe
    logic      ren;     // one cycle read strobe
  } sys_req_t;

  typedef struct packed {
    bus_data_t rdata;
    logic      ack;
    logic      err;     // unmapped address
  } sys_rsp_t;

  // decoded register select
  typedef enum logic [2:0] {
    sel_ctrl,
    sel_min_a,
    sel_max_a,
    sel_min_b,
    sel_max_b,
    sel_none
  } reg_sel_e;

endpackage

/* hdl/afe_params.svh */
// analog front end parameters
`ifndef AFE_PARAMS_SVH
`define AFE_PARAMS_SVH

////////////////////
// data widths
////////////////////

`define AFE_RAW_W        16      // ADC pin word, 2 reserved lsbs
`define AFE_SMP_W        14      // converter sample
`define AFE_SUM_W        15      // gen + ctl before saturation

////////////////////
// system bus
////////////////////

`define AFE_BUS_AW       8
`define AFE_BUS_DW       32

// register map
`define AFE_REG_CTRL     8'h00   // bit 0 digital loopback
`define AFE_REG_MIN_A    8'h10
`define AFE_REG_MAX_A    8'h14
`define AFE_REG_MIN_B    8'h18
`define AFE_REG_MAX_B    8'h1C

// limiter defaults, full 14-bit range
`define AFE_LIM_MIN_RST  (-8192)
`define AFE_LIM_MAX_RST  8191

`endif
